/* src/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int OP_W  = 4;

    // operation class, picks the unit in slot eu0
    typedef enum logic [1:0] {
        UT_NONE = 2'd0,
        UT_ALU  = 2'd1,
        UT_MUL  = 2'd2,
        UT_BR   = 2'd3
    } uop_type_e;

    typedef enum logic [OP_W-1:0] {
        ADD  = 4'd0,  SUB  = 4'd1,  SLT = 4'd2,  SLTU = 4'd3,
        AND  = 4'd4,  OR   = 4'd5,  XOR = 4'd6,  NOR  = 4'd7,
        SLL  = 4'd8,  SRL  = 4'd9,  SRA = 4'd10
    } alu_op_e;

    // same codes as the decoder's branch field
    typedef enum logic [OP_W-1:0] {
        JIRL = 4'b0011, B    = 4'b0100, BL  = 4'b0101,
        BEQ  = 4'b0110, BNE  = 4'b0111, BLT = 4'b1000,
        BGE  = 4'b1001, BLTU = 4'b1010, BGEU = 4'b1011
    } br_op_e;

    typedef enum logic [OP_W-1:0] {
        MUL_W   = 4'd0,
        MULH_W  = 4'd1,
        MULH_WU = 4'd2
    } mul_op_e;

endpackage

`default_nettype wire

/* src/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
    input  wire logic                          en,
    input  var  exe_pkg::alu_op_e              op,
    input  wire logic [exe_pkg::REG_W-1:0]     rd,
    input  wire logic [exe_pkg::XLEN-1:0]      src0,
    input  wire logic [exe_pkg::XLEN-1:0]      src1,
    output logic                               en_out,
    output logic [exe_pkg::REG_W-1:0]          rd_out,
    output logic [exe_pkg::XLEN-1:0]           result
);

    logic [exe_pkg::XLEN-1:0] res;
    logic [4:0]               shamt;

    assign shamt = src1[4:0];

    always_comb begin
        res = '0;
        case (op)
            exe_pkg::ADD:  res = src0 + src1;
            exe_pkg::SUB:  res = src0 - src1;
            exe_pkg::SLT:  res[0] = $signed(src0) < $signed(src1);
            exe_pkg::SLTU: res[0] = src0 < src1;
            exe_pkg::AND:  res = src0 & src1;
            exe_pkg::OR:   res = src0 | src1;
            exe_pkg::XOR:  res = src0 ^ src1;
            exe_pkg::NOR:  res = ~(src0 | src1);
            exe_pkg::SLL:  res = src0 << shamt;
            exe_pkg::SRL:  res = src0 >> shamt;
            exe_pkg::SRA:  res = $unsigned($signed(src0) >>> shamt);
            default:       res = '0;
        endcase
    end

    // idle unit drives zeros so results can be OR merged
    assign en_out = en;
    assign rd_out = en ? rd : '0;
    assign result = en ? res : '0;

endmodule

`default_nettype wire

/* src/exe_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_branch (
    input  wire logic                          en,
    input  var  exe_pkg::br_op_e               op,
    input  wire logic [exe_pkg::XLEN-1:0]      pc,
    input  wire logic [exe_pkg::XLEN-1:0]      pc_next,
    input  wire logic [exe_pkg::XLEN-1:0]      imm,
    input  wire logic [exe_pkg::REG_W-1:0]     rd,
    input  wire logic [exe_pkg::XLEN-1:0]      src0,
    input  wire logic [exe_pkg::XLEN-1:0]      src1,
    output logic                               link_en,
    output logic [exe_pkg::REG_W-1:0]          link_rd,
    output logic [exe_pkg::XLEN-1:0]           link_data,
    output logic                               valid,
    output logic                               taken,
    output logic [exe_pkg::XLEN-1:0]           target,
    output logic                               flush
);

    logic                     cond;
    logic                     is_link;
    logic [exe_pkg::XLEN-1:0] pc_seq;
    logic [exe_pkg::XLEN-1:0] dest;
    logic [exe_pkg::XLEN-1:0] next_pc;

    always_comb begin
        case (op)
            exe_pkg::JIRL, exe_pkg::B, exe_pkg::BL: cond = 1'b1;
            exe_pkg::BEQ:  cond = src0 == src1;
            exe_pkg::BNE:  cond = src0 != src1;
            exe_pkg::BLT:  cond = $signed(src0) < $signed(src1);
            exe_pkg::BGE:  cond = $signed(src0) >= $signed(src1);
            exe_pkg::BLTU: cond = src0 < src1;
            exe_pkg::BGEU: cond = src0 >= src1;
            default:       cond = 1'b0;
        endcase
    end

    assign is_link = (op == exe_pkg::BL) || (op == exe_pkg::JIRL);
    assign pc_seq  = pc + 4;
    // jirl is register relative, the rest pc relative
    assign dest    = ((op == exe_pkg::JIRL) ? src0 : pc) + imm;
    assign next_pc = cond ? dest : pc_seq;

    assign valid  = en;
    assign taken  = en && cond;
    assign target = en ? dest : '0;
    assign flush  = en && (next_pc != pc_next);

    assign link_en   = en && is_link;
    assign link_rd   = link_en ? rd : '0;
    assign link_data = link_en ? pc_seq : '0;

endmodule

`default_nettype wire

/* src/exe_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_mul (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire logic                          stall,
    input  wire logic                          en,
    input  var  exe_pkg::mul_op_e              op,
    input  wire logic [exe_pkg::REG_W-1:0]     rd,
    input  wire logic [exe_pkg::XLEN-1:0]      src0,
    input  wire logic [exe_pkg::XLEN-1:0]      src1,
    output logic                               en_out,
    output logic [exe_pkg::REG_W-1:0]          rd_out,
    output logic [exe_pkg::XLEN-1:0]           result
);

    logic               ext0;
    logic               ext1;
    logic signed [16:0] a_lo, a_hi;
    logic signed [16:0] b_lo, b_hi;
    logic signed [33:0] pp_ll, pp_lh, pp_hl, pp_hh;
    logic signed [33:0] r_ll, r_lh, r_hl, r_hh;
    logic               r_en;
    logic               r_high;
    logic [exe_pkg::REG_W-1:0] r_rd;
    logic signed [63:0] prod;

    // upper halves carry the sign only for mulh.w
    assign ext0 = (op == exe_pkg::MULH_W) && src0[exe_pkg::XLEN-1];
    assign ext1 = (op == exe_pkg::MULH_W) && src1[exe_pkg::XLEN-1];
    assign a_lo = {1'b0, src0[15:0]};
    assign a_hi = {ext0, src0[31:16]};
    assign b_lo = {1'b0, src1[15:0]};
    assign b_hi = {ext1, src1[31:16]};

    assign pp_ll = a_lo * b_lo;
    assign pp_lh = a_lo * b_hi;
    assign pp_hl = a_hi * b_lo;
    assign pp_hh = a_hi * b_hi;

    always_ff @(posedge clk) begin
        if (!rstn || stall) begin
            r_en   <= 1'b0;
            r_high <= 1'b0;
            r_rd   <= '0;
            r_ll   <= '0;
            r_lh   <= '0;
            r_hl   <= '0;
            r_hh   <= '0;
        end else begin
            r_en   <= en;
            r_high <= op != exe_pkg::MUL_W;
            r_rd   <= rd;
            r_ll   <= pp_ll;
            r_lh   <= pp_lh;
            r_hl   <= pp_hl;
            r_hh   <= pp_hh;
        end
    end

    // second stage
    assign prod = 64'(r_ll) + (64'(r_lh) <<< 16) + (64'(r_hl) <<< 16) + (64'(r_hh) <<< 32);

    assign en_out = r_en;
    assign rd_out = r_en ? r_rd : '0;
    assign result = !r_en ? '0 : (r_high ? prod[63:32] : prod[31:0]);

    a_mul_accepted: assert property (
        @(posedge clk) disable iff (!rstn) en_out |-> $past(en && !stall)
    ) else $error("multiply result without an accepted multiply");

endmodule

`default_nettype wire

/* src/exe_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_forward (
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rk,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rk,
    input  wire logic [exe_pkg::XLEN-1:0]      data00,
    input  wire logic [exe_pkg::XLEN-1:0]      data01,
    input  wire logic [exe_pkg::XLEN-1:0]      data10,
    input  wire logic [exe_pkg::XLEN-1:0]      data11,
    input  wire logic                          mid_en0,
    input  wire logic [exe_pkg::REG_W-1:0]     mid_rd0,
    input  wire logic [exe_pkg::XLEN-1:0]      mid_data0,
    input  wire logic                          mid_en1,
    input  wire logic [exe_pkg::REG_W-1:0]     mid_rd1,
    input  wire logic [exe_pkg::XLEN-1:0]      mid_data1,
    input  wire logic                          out_en0,
    input  wire logic [exe_pkg::REG_W-1:0]     out_rd0,
    input  wire logic [exe_pkg::XLEN-1:0]      out_data0,
    input  wire logic                          out_en1,
    input  wire logic [exe_pkg::REG_W-1:0]     out_rd1,
    input  wire logic [exe_pkg::XLEN-1:0]      out_data1,
    output logic [exe_pkg::XLEN-1:0]           eu0_src0,
    output logic [exe_pkg::XLEN-1:0]           eu0_src1,
    output logic [exe_pkg::XLEN-1:0]           eu1_src0,
    output logic [exe_pkg::XLEN-1:0]           eu1_src1
);

    // youngest producer first, r0 always from the register file
    function automatic logic [exe_pkg::XLEN-1:0] pick(
        input logic [exe_pkg::REG_W-1:0] addr,
        input logic [exe_pkg::XLEN-1:0]  rf_val
    );
        logic [exe_pkg::XLEN-1:0] val;
        if (addr == '0)
            val = rf_val;
        else if (mid_en1 && mid_rd1 == addr)
            val = mid_data1;
        else if (mid_en0 && mid_rd0 == addr)
            val = mid_data0;
        else if (out_en1 && out_rd1 == addr)
            val = out_data1;
        else if (out_en0 && out_rd0 == addr)
            val = out_data0;
        else
            val = rf_val;
        return val;
    endfunction

    always_comb begin
        eu0_src0 = pick(eu0_rj, data00);
        eu0_src1 = pick(eu0_rk, data01);
        eu1_src0 = pick(eu1_rj, data10);
        eu1_src1 = pick(eu1_rk, data11);
    end

    always_comb begin
        a_addr_known: assert (!$isunknown({eu0_rj, eu0_rk, eu1_rj, eu1_rk}))
            else $error("unknown source address at the bypass");
    end

endmodule

`default_nettype wire

/* src/exe_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_hazard (
    input  wire logic                          eu0_en,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rk,
    input  wire logic                          eu1_en,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rk,
    input  wire logic                          mid_mul_en,
    input  wire logic [exe_pkg::REG_W-1:0]     mid_mul_rd,
    output logic                               stall
);

    logic live;
    logic hit0;
    logic hit1;

    // multiply result only reaches the bypass from the output register
    assign live  = mid_mul_en && (mid_mul_rd != '0);
    assign hit0  = eu0_en && (eu0_rj == mid_mul_rd || eu0_rk == mid_mul_rd);
    assign hit1  = eu1_en && (eu1_rj == mid_mul_rd || eu1_rk == mid_mul_rd);
    assign stall = live && (hit0 || hit1);

    always_comb begin
        a_stall_has_user: assert (!stall || eu0_en || eu1_en)
            else $error("stall without an incoming operation");
    end

endmodule

`default_nettype wire

/* src/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire logic                          eu0_en,
    input  wire logic [1:0]                    eu0_type,
    input  wire logic [exe_pkg::OP_W-1:0]      eu0_op,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rd,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu0_rk,
    input  wire logic [exe_pkg::XLEN-1:0]      eu0_imm,
    input  wire logic [exe_pkg::XLEN-1:0]      eu0_pc,
    input  wire logic [exe_pkg::XLEN-1:0]      eu0_pc_next,
    input  wire logic [exe_pkg::XLEN-1:0]      data00,
    input  wire logic [exe_pkg::XLEN-1:0]      data01,
    input  wire logic                          eu1_en,
    input  wire logic [exe_pkg::OP_W-1:0]      eu1_op,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rd,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rj,
    input  wire logic [exe_pkg::REG_W-1:0]     eu1_rk,
    input  wire logic [exe_pkg::XLEN-1:0]      data10,
    input  wire logic [exe_pkg::XLEN-1:0]      data11,
    output logic                               en_out0,
    output logic [exe_pkg::REG_W-1:0]          addr_out0,
    output logic [exe_pkg::XLEN-1:0]           data_out0,
    output logic                               en_out1,
    output logic [exe_pkg::REG_W-1:0]          addr_out1,
    output logic [exe_pkg::XLEN-1:0]           data_out1,
    output logic                               stall,
    output logic                               flush,
    output logic                               branch_valid,
    output logic                               branch_taken,
    output logic [exe_pkg::XLEN-1:0]           branch_target
);

    logic                      eu0_alu_en;
    logic                      eu0_mul_en;
    logic                      eu0_br_en;
    logic                      eu0_valid;
    logic [exe_pkg::XLEN-1:0]  eu0_src0, eu0_src1;
    logic [exe_pkg::XLEN-1:0]  eu1_src0, eu1_src1;

    logic                      alu0_en, alu1_en, link_en, mul_en;
    logic [exe_pkg::REG_W-1:0] alu0_rd, alu1_rd, link_rd, mul_rd;
    logic [exe_pkg::XLEN-1:0]  alu0_res, alu1_res, link_data, mul_res;

    logic                      mid_en0, mid_en1, mid_mul;
    logic [exe_pkg::REG_W-1:0] mid_rd0, mid_rd1;
    logic [exe_pkg::XLEN-1:0]  mid_data0, mid_data1;

    assign eu0_alu_en = eu0_en && (eu0_type == exe_pkg::UT_ALU);
    assign eu0_mul_en = eu0_en && (eu0_type == exe_pkg::UT_MUL);
    assign eu0_br_en  = eu0_en && (eu0_type == exe_pkg::UT_BR);
    assign eu0_valid  = eu0_alu_en || eu0_mul_en || eu0_br_en;

    // bubble into the middle register while stalled
    always_ff @(posedge clk) begin
        if (!rstn || stall) begin
            mid_en0   <= 1'b0;
            mid_rd0   <= '0;
            mid_data0 <= '0;
            mid_en1   <= 1'b0;
            mid_rd1   <= '0;
            mid_data1 <= '0;
            mid_mul   <= 1'b0;
        end else begin
            mid_en0   <= alu0_en | link_en;
            mid_rd0   <= alu0_rd | link_rd;
            mid_data0 <= alu0_res | link_data;
            mid_en1   <= alu1_en;
            mid_rd1   <= alu1_rd;
            mid_data1 <= alu1_res;
            mid_mul   <= eu0_mul_en;
        end
    end

    // output register never holds
    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_out0   <= 1'b0;
            addr_out0 <= '0;
            data_out0 <= '0;
            en_out1   <= 1'b0;
            addr_out1 <= '0;
            data_out1 <= '0;
        end else begin
            en_out0   <= mid_en0 | mul_en;
            addr_out0 <= mid_rd0 | mul_rd;
            data_out0 <= mid_data0 | mul_res;
            en_out1   <= mid_en1;
            addr_out1 <= mid_rd1;
            data_out1 <= mid_data1;
        end
    end

    exe_forward u_forward (
        .eu0_rj    (eu0_rj),
        .eu0_rk    (eu0_rk),
        .eu1_rj    (eu1_rj),
        .eu1_rk    (eu1_rk),
        .data00    (data00),
        .data01    (data01),
        .data10    (data10),
        .data11    (data11),
        .mid_en0   (mid_en0),
        .mid_rd0   (mid_rd0),
        .mid_data0 (mid_data0),
        .mid_en1   (mid_en1),
        .mid_rd1   (mid_rd1),
        .mid_data1 (mid_data1),
        .out_en0   (en_out0),
        .out_rd0   (addr_out0),
        .out_data0 (data_out0),
        .out_en1   (en_out1),
        .out_rd1   (addr_out1),
        .out_data1 (data_out1),
        .eu0_src0  (eu0_src0),
        .eu0_src1  (eu0_src1),
        .eu1_src0  (eu1_src0),
        .eu1_src1  (eu1_src1)
    );

    exe_hazard u_hazard (
        .eu0_en     (eu0_valid),
        .eu0_rj     (eu0_rj),
        .eu0_rk     (eu0_rk),
        .eu1_en     (eu1_en),
        .eu1_rj     (eu1_rj),
        .eu1_rk     (eu1_rk),
        .mid_mul_en (mid_mul),
        .mid_mul_rd (mul_rd),
        .stall      (stall)
    );

    exe_branch u_branch (
        .en        (eu0_br_en && !stall),
        .op        (exe_pkg::br_op_e'(eu0_op)),
        .pc        (eu0_pc),
        .pc_next   (eu0_pc_next),
        .imm       (eu0_imm),
        .rd        (eu0_rd),
        .src0      (eu0_src0),
        .src1      (eu0_src1),
        .link_en   (link_en),
        .link_rd   (link_rd),
        .link_data (link_data),
        .valid     (branch_valid),
        .taken     (branch_taken),
        .target    (branch_target),
        .flush     (flush)
    );

    exe_mul u_mul (
        .clk    (clk),
        .rstn   (rstn),
        .stall  (stall),
        .en     (eu0_mul_en),
        .op     (exe_pkg::mul_op_e'(eu0_op)),
        .rd     (eu0_rd),
        .src0   (eu0_src0),
        .src1   (eu0_src1),
        .en_out (mul_en),
        .rd_out (mul_rd),
        .result (mul_res)
    );

    exe_alu u_alu0 (
        .en     (eu0_alu_en),
        .op     (exe_pkg::alu_op_e'(eu0_op)),
        .rd     (eu0_rd),
        .src0   (eu0_src0),
        .src1   (eu0_src1),
        .en_out (alu0_en),
        .rd_out (alu0_rd),
        .result (alu0_res)
    );

    exe_alu u_alu1 (
        .en     (eu1_en),
        .op     (exe_pkg::alu_op_e'(eu1_op)),
        .rd     (eu1_rd),
        .src0   (eu1_src0),
        .src1   (eu1_src1),
        .en_out (alu1_en),
        .rd_out (alu1_rd),
        .result (alu1_res)
    );

    a_flush_valid: assert property (
        @(posedge clk) disable iff (!rstn) flush |-> branch_valid
    ) else $error("flush without a resolved branch");

endmodule

`default_nettype wire

/* verif/exe_model.svh */
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [31:0] r;
    case (op)
        exe_pkg::ADD:  r = a + b;
        exe_pkg::SUB:  r = a - b;
        exe_pkg::SLT:  r = {31'b0, $signed(a) < $signed(b)};
        exe_pkg::SLTU: r = {31'b0, a < b};
        exe_pkg::AND:  r = a & b;
        exe_pkg::OR:   r = a | b;
        exe_pkg::XOR:  r = a ^ b;
        exe_pkg::NOR:  r = ~(a | b);
        exe_pkg::SLL:  r = a << b[4:0];
        exe_pkg::SRL:  r = a >> b[4:0];
        exe_pkg::SRA:  r = $signed(a) >>> b[4:0];
        default:       r = '0;
    endcase
    return r;
endfunction

function automatic logic [31:0] mul_ref(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [63:0] p;
    if (op == exe_pkg::MULH_W) begin
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return p[63:32];
    end
    p = {32'b0, a} * {32'b0, b};
    return (op == exe_pkg::MULH_WU) ? p[63:32] : p[31:0];
endfunction

function automatic logic br_taken_ref(input logic [3:0] op, input logic [31:0] a,
                                      input logic [31:0] b);
    case (op)
        exe_pkg::JIRL, exe_pkg::B, exe_pkg::BL: return 1'b1;
        exe_pkg::BEQ:  return a == b;
        exe_pkg::BNE:  return a != b;
        exe_pkg::BLT:  return $signed(a) < $signed(b);
        exe_pkg::BGE:  return $signed(a) >= $signed(b);
        exe_pkg::BLTU: return a < b;
        exe_pkg::BGEU: return a >= b;
        default:       return 1'b0;
    endcase
endfunction

// jirl jumps register relative
function automatic logic [31:0] br_target_ref(input logic [3:0] op, input logic [31:0] pc,
                                              input logic [31:0] imm, input logic [31:0] a);
    return ((op == exe_pkg::JIRL) ? a : pc) + imm;
endfunction

`endif

/* verif/exe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_tb;

    `include "exe_model.svh"

    logic        clk;
    logic        rstn;
    logic        eu0_en, eu1_en;
    logic [1:0]  eu0_type;
    logic [3:0]  eu0_op, eu1_op;
    logic [4:0]  eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    logic [31:0] eu0_imm, eu0_pc, eu0_pc_next;
    logic [31:0] data00, data01, data10, data11;
    logic        en_out0, en_out1, stall, flush;
    logic        branch_valid, branch_taken;
    logic [4:0]  addr_out0, addr_out1;
    logic [31:0] data_out0, data_out1, branch_target;

    logic [31:0] shadow_rf [0:31];
    logic [31:0] arch_rf [0:31];
    logic [3:0]  br_ops [0:8];
    int          due_q [$];
    logic [75:0] exp_q [$];
    int          cnt;
    int          seed;
    logic        mul_live;
    logic [4:0]  mul_rd;
    int          err_data, err_br, err_stall, err_to;

    exe_stage DUT (
        .clk(clk), .rstn(rstn),
        .eu0_en(eu0_en), .eu0_type(eu0_type), .eu0_op(eu0_op), .eu0_rd(eu0_rd),
        .eu0_rj(eu0_rj), .eu0_rk(eu0_rk), .eu0_imm(eu0_imm), .eu0_pc(eu0_pc),
        .eu0_pc_next(eu0_pc_next), .data00(data00), .data01(data01),
        .eu1_en(eu1_en), .eu1_op(eu1_op), .eu1_rd(eu1_rd), .eu1_rj(eu1_rj),
        .eu1_rk(eu1_rk), .data10(data10), .data11(data11),
        .en_out0(en_out0), .addr_out0(addr_out0), .data_out0(data_out0),
        .en_out1(en_out1), .addr_out1(addr_out1), .data_out1(data_out1),
        .stall(stall), .flush(flush), .branch_valid(branch_valid),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cnt <= cnt + 1;

    // compare process and register file write port
    always @(negedge clk) begin
        if (rstn) begin
            if (exp_q.size() > 0 && due_q[0] == cnt) begin
                assert ({en_out0, addr_out0, data_out0, en_out1, addr_out1, data_out1}
                        === exp_q[0])
                else begin
                    $display("ERR %0t: write-back %b %h %h / %b %h %h, expected %h", $time,
                             en_out0, addr_out0, data_out0, en_out1, addr_out1, data_out1,
                             exp_q[0]);
                    err_data++;
                end
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end else begin
                assert (en_out0 === 1'b0 && en_out1 === 1'b0)
                else begin
                    $display("ERR %0t: unexpected write-back enable", $time);
                    err_data++;
                end
            end
            if (en_out0 && addr_out0 != 0)
                shadow_rf[addr_out0] = data_out0;
            if (en_out1 && addr_out1 != 0)
                shadow_rf[addr_out1] = data_out1;
        end
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic print_counts();
        $display("errors: data %0d, branch %0d, stall %0d, timeout %0d",
                 err_data, err_br, err_stall, err_to);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        err_to++;
        print_counts();
        $display(">>> FAIL");
        $finish;
    endtask

    // stale register file read that the bypass has to correct
    task automatic drive_data();
        data00 = shadow_rf[eu0_rj];
        data01 = shadow_rf[eu0_rk];
        data10 = shadow_rf[eu1_rj];
        data11 = shadow_rf[eu1_rk];
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        @(negedge clk);
        assert (stall === 1'b0 && flush === 1'b0 && branch_valid === 1'b0)
        else begin
            $display("ERR %0t: stall, flush or branch_valid high while idle", $time);
            err_stall++;
        end
        mul_live = 1'b0;
    endtask

    task automatic issue(input logic e0, input logic [1:0] t0, input logic [3:0] op0,
                         input logic [4:0] rd0, input logic [4:0] rj0, input logic [4:0] rk0,
                         input logic [31:0] imm0, input logic [31:0] pc0,
                         input logic [31:0] pcn0, input logic e1, input logic [3:0] op1,
                         input logic [4:0] rd1, input logic [4:0] rj1, input logic [4:0] rk1);
        int          tries;
        logic        exp_st;
        logic        tk;
        logic        w0;
        logic [31:0] r0v, r1v, tgt, nxt;
        logic [75:0] ex;
        @(posedge clk);
        #2;
        eu0_en = e0;
        eu0_type = t0;
        eu0_op = op0;
        eu0_rd = rd0;
        eu0_rj = rj0;
        eu0_rk = rk0;
        eu0_imm = imm0;
        eu0_pc = pc0;
        eu0_pc_next = pcn0;
        eu1_en = e1;
        eu1_op = op1;
        eu1_rd = rd1;
        eu1_rj = rj1;
        eu1_rk = rk1;
        drive_data();
        tries = 0;
        while (1) begin
            @(negedge clk);
            exp_st = mul_live && ((e0 && (rj0 == mul_rd || rk0 == mul_rd)) ||
                                  (e1 && (rj1 == mul_rd || rk1 == mul_rd)));
            assert (stall === exp_st)
            else begin
                $display("ERR %0t: stall %b, expected %b", $time, stall, exp_st);
                err_stall++;
            end
            mul_live = 1'b0;
            if (!stall)
                break;
            tries++;
            if (tries > 3)
                abort_run("operation was never accepted, stall stuck high");
            @(posedge clk);
            #2;
            drive_data();
        end
        ex = '0;
        w0 = 1'b0;
        r0v = '0;
        if (e0 && t0 == exe_pkg::UT_BR) begin
            tk = br_taken_ref(op0, arch_rf[rj0], arch_rf[rk0]);
            tgt = br_target_ref(op0, pc0, imm0, arch_rf[rj0]);
            nxt = tk ? tgt : pc0 + 4;
            assert (branch_valid === 1'b1 && branch_taken === tk && branch_target === tgt &&
                    flush === (nxt != pcn0))
            else begin
                $display("ERR %0t: branch %b %b %h %b, expected taken %b target %h", $time,
                         branch_valid, branch_taken, branch_target, flush, tk, tgt);
                err_br++;
            end
            w0 = (op0 == exe_pkg::BL) || (op0 == exe_pkg::JIRL);
            r0v = pc0 + 4;
        end else begin
            assert (branch_valid === 1'b0 && flush === 1'b0)
            else begin
                $display("ERR %0t: branch outputs active without a branch", $time);
                err_br++;
            end
            if (e0 && t0 == exe_pkg::UT_ALU) begin
                w0 = 1'b1;
                r0v = alu_ref(op0, arch_rf[rj0], arch_rf[rk0]);
            end else if (e0 && t0 == exe_pkg::UT_MUL) begin
                w0 = 1'b1;
                r0v = mul_ref(op0, arch_rf[rj0], arch_rf[rk0]);
                mul_live = rd0 != 0;
                mul_rd = rd0;
            end
        end
        r1v = alu_ref(op1, arch_rf[rj1], arch_rf[rk1]);
        if (w0)
            ex[75:38] = {1'b1, rd0, r0v};
        if (e1)
            ex[37:0] = {1'b1, rd1, r1v};
        if (w0 || e1) begin
            due_q.push_back(cnt + 2);
            exp_q.push_back(ex);
        end
        // program order with eu1 as the younger slot
        if (w0 && rd0 != 0)
            arch_rf[rd0] = r0v;
        if (e1 && rd1 != 0)
            arch_rf[rd1] = r1v;
    endtask

    task automatic alu_op(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rj,
                          input logic [4:0] rk);
        issue(1, exe_pkg::UT_ALU, op, rd, rj, rk, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic mul_pair(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [4:0] rk, input logic e1, input logic [4:0] rj1);
        issue(1, exe_pkg::UT_MUL, op, rd, rj, rk, 0, 0, 0, e1, exe_pkg::ADD, 20, rj1, 0);
    endtask

    task automatic rand_pair(input int unsigned nreg, input logic [1:0] t0);
        logic [3:0] op0;
        logic [4:0] rd0, rj1, rk1;
        op0 = (t0 == exe_pkg::UT_MUL) ? rnd(3) : rnd(11);
        rd0 = rnd(nreg);
        rj1 = rnd(nreg);
        rk1 = rnd(nreg);
        if (rd0 != 0 && rj1 == rd0)
            rj1 = 0;
        if (rd0 != 0 && rk1 == rd0)
            rk1 = 0;
        issue(1, t0, op0, rd0, rnd(nreg), rnd(nreg), 0, 0, 0,
              rnd(2), rnd(11), rnd(nreg), rj1, rk1);
    endtask

    task automatic rand_branch();
        logic [3:0]  op;
        logic [4:0]  rj, rk;
        logic [31:0] pc, imm, tgt, nxt, pcn;
        logic        tk;
        op = br_ops[rnd(9)];
        rj = 1 + rnd(31);
        rk = rnd(2) ? rj : 1 + rnd(31);
        pc = $random(seed) & 32'hFFFF_FFFC;
        imm = $random(seed);
        imm = {{14{imm[17]}}, imm[17:2], 2'b00};
        tk = br_taken_ref(op, arch_rf[rj], arch_rf[rk]);
        tgt = br_target_ref(op, pc, imm, arch_rf[rj]);
        nxt = tk ? tgt : pc + 4;
        pcn = rnd(2) ? nxt : (tk ? pc + 4 : tgt);
        issue(1, exe_pkg::UT_BR, op, 1 + rnd(31), rj, rk, imm, pc, pcn, 0, 0, 0, 0, 0);
    endtask

    initial begin
        #2_000_000;
        abort_run("simulation time limit reached");
    end

    initial begin
        int          guard;
        logic [31:0] pc;
        clk = 0;
        rstn = 0;
        cnt = 0;
        seed = 71;
        eu0_en = 0;
        eu0_type = 0;
        eu0_op = 0;
        eu0_rd = 0;
        eu0_rj = 0;
        eu0_rk = 0;
        eu0_imm = 0;
        eu0_pc = 0;
        eu0_pc_next = 0;
        data00 = 0;
        data01 = 0;
        eu1_en = 0;
        eu1_op = 0;
        eu1_rd = 0;
        eu1_rj = 0;
        eu1_rk = 0;
        data10 = 0;
        data11 = 0;
        mul_live = 0;
        mul_rd = 0;
        err_data = 0;
        err_br = 0;
        err_stall = 0;
        err_to = 0;
        br_ops = '{exe_pkg::JIRL, exe_pkg::B, exe_pkg::BL, exe_pkg::BEQ, exe_pkg::BNE,
                   exe_pkg::BLT, exe_pkg::BGE, exe_pkg::BLTU, exe_pkg::BGEU};
        for (int i = 0; i < 32; i++) begin
            shadow_rf[i] = '0;
            arch_rf[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1;
        repeat (4) idle_cycle();

        // load every register through bl links
        for (int r = 1; r < 32; r++) begin
            pc = (r == 1) ? 32'h7FFF_FFFC : (r == 2) ? 32'hFFFF_FFFB : $random(seed);
            issue(1, exe_pkg::UT_BR, exe_pkg::BL, r, 0, 0, 32'h40, pc, pc + 32'h40,
                  0, 0, 0, 0, 0);
        end
        repeat (40) rand_pair(32, exe_pkg::UT_ALU);

        // dependent chain and same-register pair
        alu_op(exe_pkg::ADD, 5, 3, 4);
        alu_op(exe_pkg::SUB, 6, 5, 7);
        alu_op(exe_pkg::XOR, 7, 5, 6);
        issue(1, exe_pkg::UT_ALU, exe_pkg::OR, 8, 3, 4, 0, 0, 0, 1, exe_pkg::AND, 8, 5, 6);
        alu_op(exe_pkg::ADD, 9, 8, 0);
        alu_op(exe_pkg::ADD, 10, 8, 9);
        idle_cycle();
        alu_op(exe_pkg::SRA, 11, 8, 10);
        repeat (40) rand_pair(8, exe_pkg::UT_ALU);

        // r1 gets 0x80000000 and r2 gets 0xffffffff for the multiplier
        for (int r = 1; r < 3; r++) begin
            pc = (r == 1) ? 32'h7FFF_FFFC : 32'hFFFF_FFFB;
            issue(1, exe_pkg::UT_BR, exe_pkg::BL, r, 0, 0, 32'h40, pc, pc + 32'h40,
                  0, 0, 0, 0, 0);
        end
        for (int op = 0; op < 3; op++) begin
            mul_pair(op, 12, 1, 2, 0, 0);
            mul_pair(op, 13, 1, 1, 0, 0);
            mul_pair(op, 14, 2, 2, 1, 3);
        end
        repeat (20) rand_pair(32, exe_pkg::UT_MUL);

        // multiply-use stalls and an rd 0 multiply that must not stall
        mul_pair(exe_pkg::MUL_W, 12, 3, 4, 0, 0);
        alu_op(exe_pkg::ADD, 13, 12, 5);
        mul_pair(exe_pkg::MULH_W, 14, 2, 6, 0, 0);
        issue(1, exe_pkg::UT_ALU, exe_pkg::OR, 15, 1, 2, 0, 0, 0, 1, exe_pkg::SUB, 16, 14, 14);
        mul_pair(exe_pkg::MULH_WU, 0, 1, 2, 0, 0);
        alu_op(exe_pkg::ADD, 17, 0, 3);

        repeat (40) rand_branch();
        repeat (80) begin
            case (rnd(3))
                0: rand_pair(8, exe_pkg::UT_ALU);
                1: rand_pair(8, exe_pkg::UT_MUL);
                default: rand_branch();
            endcase
        end

        guard = 0;
        while (exp_q.size() > 0) begin
            idle_cycle();
            guard++;
            if (guard > 10)
                abort_run("expected write-back results never arrived");
        end
        idle_cycle();
        print_counts();
        if (err_data + err_br + err_stall + err_to == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exe_unit.f */
+incdir+verif
src/exe_pkg.sv
src/exe_alu.sv
src/exe_branch.sv
src/exe_mul.sv
src/exe_forward.sv
src/exe_hazard.sv
src/exe_stage.sv
verif/exe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exe_tb
FLIST     ?= exe_unit.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
